// ==== iosys.f ====
iosys_pkg.sv
iosys_boot_loader.sv
iosys_mem_arbiter.sv
iosys_reg_decoder.sv
iosys_rom_streamer.sv
iosys_timebase.sv
iosys.sv
tb_iosys.sv

// ==== iosys.sv ====
`timescale 1ns/1ps
`default_nettype none

module iosys #(
    parameter int          FIRMWARE_BYTES = 256 * 1024,
    parameter int          CLK_FREQ       = 21_477_000,
    parameter logic [15:0] CORE_ID        = 16'd2
) (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 i_cpu_valid,
    input  iosys_pkg::addr_t     i_cpu_addr,
    input  iosys_pkg::word_t     i_cpu_wdata,
    input  iosys_pkg::wstrb_t    i_cpu_wstrb,
    output logic                 o_cpu_ready,
    output iosys_pkg::word_t     o_cpu_rdata,
    output logic                 o_cpu_resetn,
    input  logic                 i_ram_busy,
    output logic                 o_flash_start,
    input  logic                 i_flash_strb,
    input  iosys_pkg::byte_t     i_flash_byte,
    output logic                 o_mem_valid,
    output iosys_pkg::mem_addr_t o_mem_addr,
    output iosys_pkg::word_t     o_mem_wdata,
    output iosys_pkg::wstrb_t    o_mem_wstrb,
    input  logic                 i_mem_ready,
    input  iosys_pkg::word_t     i_mem_rdata,
    output logic                 o_rom_loading,
    output iosys_pkg::byte_t     o_rom_do,
    output logic                 o_rom_do_valid,
    output iosys_pkg::sys_type_t o_sys_type,
    output logic                 o_aspect_ratio,
    output logic                 o_enh_apu,
    output logic                 o_overlay,
    input  iosys_pkg::joy_t      i_joy1,
    input  iosys_pkg::joy_t      i_joy2
);
    import iosys_pkg::*;

    logic      boot_wr;
    mem_addr_t boot_addr;
    word_t     boot_wdata;
    wstrb_t    boot_wstrb;
    logic      boot_done;
    logic      ram_req;
    logic      ram_ready;
    word_t     ram_rdata;
    logic      rom_data_we;
    logic      rom_ctrl_we;
    word_t     time_ms;
    word_t     cycles;

    iosys_boot_loader #(
        .FIRMWARE_BYTES(FIRMWARE_BYTES)
    ) u_boot_loader (
        .clk          (clk),
        .resetn       (resetn),
        .i_ram_busy   (i_ram_busy),
        .i_flash_strb (i_flash_strb),
        .i_flash_byte (i_flash_byte),
        .o_flash_start(o_flash_start),
        .o_wr         (boot_wr),
        .o_addr       (boot_addr),
        .o_wdata      (boot_wdata),
        .o_wstrb      (boot_wstrb),
        .o_done       (boot_done)
    );

    // Softcore address is cut down to the 8 MB memory window
    iosys_mem_arbiter u_mem_arbiter (
        .clk         (clk),
        .resetn      (resetn),
        .i_boot_wr   (boot_wr),
        .i_boot_addr (boot_addr),
        .i_boot_wdata(boot_wdata),
        .i_boot_wstrb(boot_wstrb),
        .i_boot_done (boot_done),
        .i_cpu_req   (ram_req),
        .i_cpu_addr  (i_cpu_addr[$bits(mem_addr_t)-1:0]),
        .i_cpu_wdata (i_cpu_wdata),
        .i_cpu_wstrb (i_cpu_wstrb),
        .i_mem_ready (i_mem_ready),
        .i_mem_rdata (i_mem_rdata),
        .o_cpu_ready (ram_ready),
        .o_cpu_rdata (ram_rdata),
        .o_mem_valid (o_mem_valid),
        .o_mem_addr  (o_mem_addr),
        .o_mem_wdata (o_mem_wdata),
        .o_mem_wstrb (o_mem_wstrb),
        .o_cpu_resetn(o_cpu_resetn)
    );

    iosys_reg_decoder #(
        .CORE_ID(CORE_ID)
    ) u_reg_decoder (
        .clk           (clk),
        .resetn        (resetn),
        .i_cpu_valid   (i_cpu_valid),
        .i_cpu_addr    (i_cpu_addr),
        .i_cpu_wdata   (i_cpu_wdata),
        .i_cpu_wstrb   (i_cpu_wstrb),
        .i_ram_ready   (ram_ready),
        .i_ram_rdata   (ram_rdata),
        .i_time_ms     (time_ms),
        .i_cycles      (cycles),
        .i_joy1        (i_joy1),
        .i_joy2        (i_joy2),
        .o_cpu_ready   (o_cpu_ready),
        .o_cpu_rdata   (o_cpu_rdata),
        .o_ram_req     (ram_req),
        .o_rom_data_we (rom_data_we),
        .o_rom_ctrl_we (rom_ctrl_we),
        .o_sys_type    (o_sys_type),
        .o_aspect_ratio(o_aspect_ratio),
        .o_enh_apu     (o_enh_apu),
        .o_overlay     (o_overlay)
    );

    iosys_rom_streamer u_rom_streamer (
        .clk           (clk),
        .resetn        (resetn),
        .i_data_we     (rom_data_we),
        .i_ctrl_we     (rom_ctrl_we),
        .i_wdata       (i_cpu_wdata),
        .o_rom_do      (o_rom_do),
        .o_rom_do_valid(o_rom_do_valid),
        .o_rom_loading (o_rom_loading)
    );

    iosys_timebase #(
        .CLK_FREQ(CLK_FREQ)
    ) u_timebase (
        .clk      (clk),
        .resetn   (resetn),
        .o_time_ms(time_ms),
        .o_cycles (cycles)
    );

endmodule

`default_nettype wire

// ==== iosys_boot_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module iosys_boot_loader #(
    parameter int FIRMWARE_BYTES = 256 * 1024
) (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 i_ram_busy,
    input  logic                 i_flash_strb,
    input  iosys_pkg::byte_t     i_flash_byte,
    output logic                 o_flash_start,
    output logic                 o_wr,
    output iosys_pkg::mem_addr_t o_addr,
    output iosys_pkg::word_t     o_wdata,
    output iosys_pkg::wstrb_t    o_wstrb,
    output logic                 o_done
);
    import iosys_pkg::*;

    boot_state_t state;
    mem_addr_t   next_addr;

    assign o_flash_start = (state == BOOT_START);
    assign o_done        = (state == BOOT_DONE);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state     <= BOOT_WAIT;
            next_addr <= '0;
            o_wr      <= 1'b0;
        end else begin
            o_wr <= 1'b0;
            case (state)
                // Hold off until the SDRAM has finished its init
                BOOT_WAIT: begin
                    if (!i_ram_busy) begin
                        state <= BOOT_START;
                    end
                end
                BOOT_START: state <= BOOT_COPY;
                BOOT_COPY: begin
                    if (i_flash_strb) begin
                        next_addr <= next_addr + 1'b1;
                        o_wr      <= 1'b1;
                    end
                    // Done once the last byte's write has gone out
                    if (o_wr && o_addr == mem_addr_t'(FIRMWARE_BYTES - 1)) begin
                        state <= BOOT_DONE;
                    end
                end
                default: state <= BOOT_DONE;
            endcase
        end
    end

    // Byte replicated on all lanes, the strobe picks the lane
    always_ff @(posedge clk) begin
        if (state == BOOT_COPY && i_flash_strb) begin
            o_addr  <= next_addr;
            o_wdata <= {4{i_flash_byte}};
            o_wstrb <= wstrb_t'(4'b0001 << next_addr[1:0]);
        end
    end

    // No write lands past the end of the firmware image
    a_wstrb_onehot: assert property (@(posedge clk) disable iff (!resetn)
        o_wr |-> $onehot(o_wstrb) && int'(o_addr) < FIRMWARE_BYTES);

endmodule

`default_nettype wire

// ==== iosys_mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module iosys_mem_arbiter (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 i_boot_wr,
    input  iosys_pkg::mem_addr_t i_boot_addr,
    input  iosys_pkg::word_t     i_boot_wdata,
    input  iosys_pkg::wstrb_t    i_boot_wstrb,
    input  logic                 i_boot_done,
    input  logic                 i_cpu_req,
    input  iosys_pkg::mem_addr_t i_cpu_addr,
    input  iosys_pkg::word_t     i_cpu_wdata,
    input  iosys_pkg::wstrb_t    i_cpu_wstrb,
    input  logic                 i_mem_ready,
    input  iosys_pkg::word_t     i_mem_rdata,
    output logic                 o_cpu_ready,
    output iosys_pkg::word_t     o_cpu_rdata,
    output logic                 o_mem_valid,
    output iosys_pkg::mem_addr_t o_mem_addr,
    output iosys_pkg::word_t     o_mem_wdata,
    output iosys_pkg::wstrb_t    o_mem_wstrb,
    output logic                 o_cpu_resetn
);
    import iosys_pkg::*;

    grant_t grant;

    // One-way handover, the boot loader never gets the port back
    always_ff @(posedge clk) begin
        if (!resetn) begin
            grant <= GRANT_BOOT;
        end else if (i_boot_done) begin
            grant <= GRANT_CPU;
        end
    end

    always_comb begin
        if (grant == GRANT_CPU) begin
            o_mem_valid = i_cpu_req;
            o_mem_addr  = i_cpu_addr;
            o_mem_wdata = i_cpu_wdata;
            o_mem_wstrb = i_cpu_wstrb;
        end else begin
            o_mem_valid = i_boot_wr;
            o_mem_addr  = i_boot_addr;
            o_mem_wdata = i_boot_wdata;
            o_mem_wstrb = i_boot_wstrb;
        end
    end

    // Softcore stalls on its request until the memory answers
    assign o_cpu_ready = (grant == GRANT_CPU) && i_mem_ready;
    assign o_cpu_rdata = i_mem_rdata;

    // Released together with boot done, grant follows a cycle later
    assign o_cpu_resetn = (grant == GRANT_CPU) || i_boot_done;

    a_no_cpu_during_boot: assert property (@(posedge clk) disable iff (!resetn)
        i_cpu_req |-> grant == GRANT_CPU);

endmodule

`default_nettype wire

// ==== iosys_pkg.sv ====
`default_nettype none

package iosys_pkg;

    // Bus and data widths
    typedef logic [31:0] addr_t;
    typedef logic [22:0] mem_addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  wstrb_t;
    typedef logic [7:0]  byte_t;
    typedef logic [11:0] joy_t;
    typedef logic [1:0]  sys_type_t;

    // Softcore register map
    localparam addr_t REG_OVERLAY  = 32'h0200_0000;
    localparam addr_t REG_ROM_CTRL = 32'h0200_0030;
    localparam addr_t REG_ROM_DATA = 32'h0200_0034;
    localparam addr_t REG_JOY      = 32'h0200_0040;
    localparam addr_t REG_TIME_MS  = 32'h0200_0050;
    localparam addr_t REG_CYCLES   = 32'h0200_0054;
    localparam addr_t REG_CORE_ID  = 32'h0200_0060;
    localparam addr_t REG_ENH_APU  = 32'h0200_0080;
    localparam addr_t REG_SYS_TYPE = 32'h0200_01C0;
    localparam addr_t REG_ASPECT   = 32'h0200_01E0;

    // High address bits that are zero for the 8 MB RAM window
    localparam int RAM_TOP_BITS = 9;

    typedef enum logic [1:0] {
        BOOT_WAIT,
        BOOT_START,
        BOOT_COPY,
        BOOT_DONE
    } boot_state_t;

    typedef enum logic {
        GRANT_BOOT,
        GRANT_CPU
    } grant_t;

endpackage

`default_nettype wire

// ==== iosys_reg_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module iosys_reg_decoder #(
    parameter logic [15:0] CORE_ID = 16'd1
) (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 i_cpu_valid,
    input  iosys_pkg::addr_t     i_cpu_addr,
    input  iosys_pkg::word_t     i_cpu_wdata,
    input  iosys_pkg::wstrb_t    i_cpu_wstrb,
    input  logic                 i_ram_ready,
    input  iosys_pkg::word_t     i_ram_rdata,
    input  iosys_pkg::word_t     i_time_ms,
    input  iosys_pkg::word_t     i_cycles,
    input  iosys_pkg::joy_t      i_joy1,
    input  iosys_pkg::joy_t      i_joy2,
    output logic                 o_cpu_ready,
    output iosys_pkg::word_t     o_cpu_rdata,
    output logic                 o_ram_req,
    output logic                 o_rom_data_we,
    output logic                 o_rom_ctrl_we,
    output iosys_pkg::sys_type_t o_sys_type,
    output logic                 o_aspect_ratio,
    output logic                 o_enh_apu,
    output logic                 o_overlay
);
    import iosys_pkg::*;

    logic  ram_sel;
    logic  cpu_wr;
    logic  reg_hit;
    word_t reg_rdata;

    // RAM lives in the low 8 MB
    assign ram_sel = i_cpu_valid && (i_cpu_addr[31 -: RAM_TOP_BITS] == '0);
    assign cpu_wr  = i_cpu_valid && (i_cpu_wstrb != '0);

    assign o_ram_req     = ram_sel;
    assign o_rom_data_we = cpu_wr && (i_cpu_addr == REG_ROM_DATA);
    assign o_rom_ctrl_we = cpu_wr && (i_cpu_addr == REG_ROM_CTRL);

    always_comb begin
        reg_hit   = 1'b1;
        reg_rdata = '0;
        case (i_cpu_addr)
            // Overlay reads back as the on/off code that was written
            REG_OVERLAY:  reg_rdata = {6'd0, (o_overlay ? 2'd1 : 2'd2), 24'd0};
            REG_ROM_CTRL: reg_rdata = '0;
            REG_ROM_DATA: reg_rdata = '0;
            REG_JOY:      reg_rdata = {4'd0, i_joy2, 4'd0, i_joy1};
            REG_TIME_MS:  reg_rdata = i_time_ms;
            REG_CYCLES:   reg_rdata = i_cycles;
            REG_CORE_ID:  reg_rdata = {16'd0, CORE_ID};
            REG_ENH_APU:  reg_rdata = {31'd0, o_enh_apu};
            REG_SYS_TYPE: reg_rdata = {30'd0, o_sys_type};
            REG_ASPECT:   reg_rdata = {31'd0, o_aspect_ratio};
            default:      reg_hit = 1'b0;
        endcase
    end

    // Registers answer at once, RAM waits for the memory
    assign o_cpu_ready = ram_sel ? i_ram_ready : (i_cpu_valid && reg_hit);
    assign o_cpu_rdata = ram_sel ? i_ram_rdata : reg_rdata;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            o_sys_type     <= '0;
            o_aspect_ratio <= 1'b0;
            o_enh_apu      <= 1'b0;
            o_overlay      <= 1'b1;
        end else if (cpu_wr) begin
            case (i_cpu_addr)
                REG_SYS_TYPE: o_sys_type <= i_cpu_wdata[1:0];
                REG_ASPECT:   o_aspect_ratio <= i_cpu_wdata[0];
                REG_ENH_APU:  o_enh_apu <= i_cpu_wdata[0];
                REG_OVERLAY: begin
                    // 1 turns the menu on, 2 turns it off
                    if (i_cpu_wdata[25:24] == 2'd1) begin
                        o_overlay <= 1'b1;
                    end else if (i_cpu_wdata[25:24] == 2'd2) begin
                        o_overlay <= 1'b0;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== iosys_rom_streamer.sv ====
`timescale 1ns/1ps
`default_nettype none

module iosys_rom_streamer (
    input  logic             clk,
    input  logic             resetn,
    input  logic             i_data_we,
    input  logic             i_ctrl_we,
    input  iosys_pkg::word_t i_wdata,
    output iosys_pkg::byte_t o_rom_do,
    output logic             o_rom_do_valid,
    output logic             o_rom_loading
);
    import iosys_pkg::*;

    logic [3:0] rom_cnt;
    word_t      rom_buf;

    // Counts 15 down to 0 after a data write; each byte slot is 4 cycles
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rom_cnt <= '0;
        end else if (i_data_we) begin
            rom_cnt <= 4'd15;
        end else if (rom_cnt != '0) begin
            rom_cnt <= rom_cnt - 1'b1;
        end
    end

    // Next byte moves down at the end of each slot
    always_ff @(posedge clk) begin
        if (i_data_we) begin
            rom_buf <= i_wdata;
        end else if (rom_cnt[1:0] == 2'd0 && rom_cnt[3:2] != 2'd0) begin
            rom_buf <= {8'd0, rom_buf[31:8]};
        end
    end

    // Valid on the first two cycles of every slot
    assign o_rom_do_valid = rom_cnt[1];
    assign o_rom_do       = rom_buf[7:0];

    // 1 starts a load, 0 ends it
    always_ff @(posedge clk) begin
        if (!resetn) begin
            o_rom_loading <= 1'b0;
        end else if (i_ctrl_we) begin
            if (i_wdata[7:0] == 8'd1) begin
                o_rom_loading <= 1'b1;
            end else if (i_wdata[7:0] == 8'd0) begin
                o_rom_loading <= 1'b0;
            end
        end
    end

    a_valid_max_two: assert property (@(posedge clk) disable iff (!resetn)
        o_rom_do_valid [*2] |=> !o_rom_do_valid);

endmodule

`default_nettype wire

// ==== iosys_timebase.sv ====
`timescale 1ns/1ps
`default_nettype none

module iosys_timebase #(
    parameter int CLK_FREQ = 21_477_000
) (
    input  logic             clk,
    input  logic             resetn,
    output iosys_pkg::word_t o_time_ms,
    output iosys_pkg::word_t o_cycles
);
    import iosys_pkg::*;

    localparam int MS_DIV = CLK_FREQ / 1000;
    localparam int PRE_W  = (MS_DIV > 1) ? $clog2(MS_DIV) : 1;

    logic [PRE_W-1:0] prescale;

    // Millisecond tick from the clock prescaler
    always_ff @(posedge clk) begin
        if (!resetn) begin
            prescale  <= '0;
            o_time_ms <= '0;
        end else if (prescale == PRE_W'(MS_DIV - 1)) begin
            prescale  <= '0;
            o_time_ms <= o_time_ms + 1'b1;
        end else begin
            prescale <= prescale + 1'b1;
        end
    end

    // Wraps after 2^32 cycles
    always_ff @(posedge clk) begin
        if (!resetn) begin
            o_cycles <= '0;
        end else begin
            o_cycles <= o_cycles + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log
rm -f sim.log
verilator --binary --timing --assert --top-module tb_iosys -f iosys.f -o tb_iosys \
    && ./obj_dir/tb_iosys > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST PASSED" sim.log || exit 1
exit 0

// ==== tb_iosys.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_iosys;
    import iosys_pkg::*;

    localparam int FW_BYTES   = 64;
    localparam int CLK_HZ     = 10_000;
    localparam int CYC_PER_MS = CLK_HZ / 1000;
    localparam int TIME_GAP   = 45;
    localparam int CYC_GAP    = 50;
    // Boot needs about 350 cycles and the bus tests about 300 more
    localparam int MAX_CYCLES = 3000;

    logic clk = 1'b0;
    logic resetn;
    logic i_cpu_valid;
    addr_t i_cpu_addr;
    word_t i_cpu_wdata;
    wstrb_t i_cpu_wstrb;
    logic o_cpu_ready;
    word_t o_cpu_rdata;
    logic o_cpu_resetn;
    logic i_ram_busy;
    logic o_flash_start;
    logic i_flash_strb = 1'b0;
    byte_t i_flash_byte = '0;
    logic o_mem_valid;
    mem_addr_t o_mem_addr;
    word_t o_mem_wdata;
    wstrb_t o_mem_wstrb;
    logic i_mem_ready = 1'b0;
    word_t i_mem_rdata = '0;
    logic o_rom_loading;
    byte_t o_rom_do;
    logic o_rom_do_valid;
    sys_type_t o_sys_type;
    logic o_aspect_ratio;
    logic o_enh_apu;
    logic o_overlay;
    joy_t i_joy1;
    joy_t i_joy2;

    int errors = 0;
    int accesses = 0;
    int cycle_cnt = 0;
    word_t mem [0:255];
    logic mem_busy;
    logic [1:0] mem_cnt;
    mem_addr_t mem_req_addr;
    byte_t flash_bytes [0:FW_BYTES-1];
    int flash_sent;
    logic flash_on;
    logic [2:0] flash_gap;
    logic exp_start;
    logic start_seen;
    int boot_writes;
    logic chk_en = 1'b0;
    word_t chk_mask;
    word_t chk_lo;
    word_t chk_hi;
    logic [4:0] rom_phase;
    word_t rom_word;
    logic [1:0] rom_idx;
    logic rom_exp_valid;
    byte_t rom_exp_byte;
    logic cpu_wr_done;
    logic exp_loading;
    sys_type_t exp_sys_type;
    logic exp_aspect;
    logic exp_enh_apu;
    logic exp_overlay;

    iosys #(
        .FIRMWARE_BYTES(FW_BYTES),
        .CLK_FREQ      (CLK_HZ),
        .CORE_ID       (16'd2)
    ) u_dut (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Memory model with 1 to 3 cycles until ready
    always @(posedge clk) begin
        if (!resetn) begin
            i_mem_ready <= 1'b0;
            mem_busy    <= 1'b0;
        end else if (i_mem_ready) begin
            i_mem_ready <= 1'b0;
            mem_busy    <= 1'b0;
        end else if (mem_busy) begin
            if (mem_cnt == 2'd0) begin
                i_mem_ready <= 1'b1;
                i_mem_rdata <= mem[mem_req_addr[9:2]];
            end else begin
                mem_cnt <= mem_cnt - 2'd1;
            end
        end else if (o_mem_valid) begin
            mem_busy     <= 1'b1;
            mem_cnt      <= 2'($urandom % 3);
            mem_req_addr <= o_mem_addr;
            for (int l = 0; l < 4; l++) begin
                if (o_mem_wstrb[l]) begin
                    mem[o_mem_addr[9:2]][8*l +: 8] <= o_mem_wdata[8*l +: 8];
                end
            end
        end
    end

    // One random flash byte every 5 cycles after the start pulse
    always @(posedge clk) begin
        byte_t fb;
        if (!resetn) begin
            i_flash_strb <= 1'b0;
            flash_on     <= 1'b0;
            flash_sent   <= 0;
            flash_gap    <= 3'd0;
        end else begin
            i_flash_strb <= 1'b0;
            if (o_flash_start) begin
                flash_on  <= 1'b1;
                flash_gap <= 3'd4;
            end else if (flash_on && flash_sent < FW_BYTES) begin
                if (flash_gap == 3'd0) begin
                    fb = byte_t'($urandom);
                    i_flash_strb            <= 1'b1;
                    i_flash_byte            <= fb;
                    flash_bytes[flash_sent] <= fb;
                    flash_sent              <= flash_sent + 1;
                    flash_gap               <= 3'd4;
                end else begin
                    flash_gap <= flash_gap - 3'd1;
                end
            end
        end
    end

    // Single start pulse once the RAM has left its busy phase
    always @(posedge clk) begin
        if (!resetn) begin
            exp_start  <= 1'b0;
            start_seen <= 1'b0;
        end else begin
            exp_start <= !i_ram_busy && !start_seen;
            if (!i_ram_busy) begin
                start_seen <= 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        if (!resetn) begin
            boot_writes <= 0;
        end else if (o_mem_valid && !o_cpu_resetn) begin
            boot_writes <= boot_writes + 1;
        end
    end

    // Expected register and ROM stream state
    assign cpu_wr_done = i_cpu_valid && o_cpu_ready && (i_cpu_wstrb != '0);

    always @(posedge clk) begin
        if (!resetn) begin
            rom_phase    <= 5'd0;
            exp_loading  <= 1'b0;
            exp_sys_type <= '0;
            exp_aspect   <= 1'b0;
            exp_enh_apu  <= 1'b0;
            exp_overlay  <= 1'b1;
        end else begin
            if (rom_phase != 5'd0 && rom_phase < 5'd16) begin
                rom_phase <= rom_phase + 5'd1;
            end
            if (cpu_wr_done) begin
                case (i_cpu_addr)
                    REG_ROM_DATA: begin
                        rom_phase <= 5'd1;
                        rom_word  <= i_cpu_wdata;
                    end
                    REG_ROM_CTRL: begin
                        if (i_cpu_wdata[7:0] == 8'd1) begin
                            exp_loading <= 1'b1;
                        end else if (i_cpu_wdata[7:0] == 8'd0) begin
                            exp_loading <= 1'b0;
                        end
                    end
                    REG_SYS_TYPE: exp_sys_type <= i_cpu_wdata[1:0];
                    REG_ASPECT:   exp_aspect <= i_cpu_wdata[0];
                    REG_ENH_APU:  exp_enh_apu <= i_cpu_wdata[0];
                    REG_OVERLAY: begin
                        if (i_cpu_wdata[25:24] == 2'd1) begin
                            exp_overlay <= 1'b1;
                        end else if (i_cpu_wdata[25:24] == 2'd2) begin
                            exp_overlay <= 1'b0;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // Two valid cycles then two idle per byte, LSB first
    assign rom_exp_valid = (rom_phase >= 5'd1) && (rom_phase <= 5'd14)
                           && (rom_phase[1:0] == 2'd1 || rom_phase[1:0] == 2'd2);
    assign rom_idx       = 2'((rom_phase - 5'd1) >> 2);
    assign rom_exp_byte  = rom_word[8*rom_idx +: 8];

    a_flash_start: assert property (@(posedge clk) disable iff (!resetn)
        o_flash_start == exp_start)
        else begin
            errors = errors + 1;
            $display("[ERROR] %0t: flash start is %b, expected %b", $time,
                     o_flash_start, exp_start);
        end

    a_boot_write: assert property (@(posedge clk) disable iff (!resetn)
        o_mem_valid && !o_cpu_resetn |->
            o_mem_addr == mem_addr_t'(boot_writes)
            && $onehot(o_mem_wstrb) && o_mem_wstrb[boot_writes[1:0]]
            && o_mem_wdata == {4{flash_bytes[boot_writes]}})
        else begin
            errors = errors + 1;
            $display("[ERROR] %0t: boot write %0d has addr %h strb %b data %h", $time,
                     boot_writes, o_mem_addr, o_mem_wstrb, o_mem_wdata);
        end

    a_cpu_reset_hold: assert property (@(posedge clk) disable iff (!resetn)
        o_cpu_resetn |-> boot_writes == FW_BYTES)
        else begin
            errors = errors + 1;
            $display("[ERROR] %0t: softcore released after %0d writes", $time, boot_writes);
        end

    a_ram_ready_wait: assert property (@(posedge clk) disable iff (!resetn)
        i_cpu_valid && i_cpu_addr[31:23] == 9'd0 && o_cpu_ready |-> i_mem_ready)
        else begin
            errors = errors + 1;
            $display("[ERROR] %0t: RAM access ready without memory ready", $time);
        end

    a_read_value: assert property (@(posedge clk) disable iff (!resetn)
        chk_en && i_cpu_valid && o_cpu_ready |->
            (o_cpu_rdata & chk_mask) >= chk_lo && (o_cpu_rdata & chk_mask) <= chk_hi)
        else begin
            errors = errors + 1;
            $display("[ERROR] %0t: read of %h gave %h, expected %h..%h under mask %h",
                     $time, i_cpu_addr, o_cpu_rdata, chk_lo, chk_hi, chk_mask);
        end

    a_rom_valid: assert property (@(posedge clk) disable iff (!resetn)
        o_rom_do_valid == rom_exp_valid)
        else begin
            errors = errors + 1;
            $display("[ERROR] %0t: rom valid %b at phase %0d", $time, o_rom_do_valid, rom_phase);
        end

    a_rom_byte: assert property (@(posedge clk) disable iff (!resetn)
        rom_exp_valid |-> o_rom_do == rom_exp_byte)
        else begin
            errors = errors + 1;
            $display("[ERROR] %0t: rom byte %h, expected %h", $time, o_rom_do, rom_exp_byte);
        end

    a_rom_loading: assert property (@(posedge clk) disable iff (!resetn)
        o_rom_loading == exp_loading)
        else begin
            errors = errors + 1;
            $display("[ERROR] %0t: rom loading flag is %b", $time, o_rom_loading);
        end

    a_config: assert property (@(posedge clk) disable iff (!resetn)
        o_sys_type == exp_sys_type && o_aspect_ratio == exp_aspect
        && o_enh_apu == exp_enh_apu && o_overlay == exp_overlay)
        else begin
            errors = errors + 1;
            $display("[ERROR] %0t: config outputs %h %b %b %b", $time,
                     o_sys_type, o_aspect_ratio, o_enh_apu, o_overlay);
        end

    // Softcore request held until ready
    task automatic access_bus(input addr_t addr, input word_t wdata, input wstrb_t wstrb,
                              input logic chk, input word_t mask, input word_t lo,
                              input word_t hi, output word_t rdata);
        @(posedge clk);
        i_cpu_valid <= 1'b1;
        i_cpu_addr  <= addr;
        i_cpu_wdata <= wdata;
        i_cpu_wstrb <= wstrb;
        chk_en      <= chk;
        chk_mask    <= mask;
        chk_lo      <= lo;
        chk_hi      <= hi;
        @(negedge clk);
        while (!o_cpu_ready) begin
            @(negedge clk);
        end
        rdata    = o_cpu_rdata;
        accesses = accesses + 1;
        @(posedge clk);
        i_cpu_valid <= 1'b0;
        i_cpu_wstrb <= '0;
        chk_en      <= 1'b0;
    endtask

    task automatic write_word(input addr_t addr, input word_t wdata);
        word_t discard;
        access_bus(addr, wdata, 4'hf, 1'b0, '0, '0, '0, discard);
    endtask

    task automatic read_word(input addr_t addr, output word_t rdata);
        access_bus(addr, '0, '0, 1'b0, '0, '0, '0, rdata);
    endtask

    task automatic expect_read(input addr_t addr, input word_t mask, input word_t lo,
                               input word_t hi);
        word_t discard;
        access_bus(addr, '0, '0, 1'b1, mask, lo, hi, discard);
    endtask

    initial begin
        word_t t_first;
        word_t wv;
        addr_t ra;
        void'($urandom(32'h6e2a));
        resetn      <= 1'b0;
        i_ram_busy  <= 1'b1;
        i_cpu_valid <= 1'b0;
        i_cpu_addr  <= '0;
        i_cpu_wdata <= '0;
        i_cpu_wstrb <= '0;
        i_joy1      <= joy_t'($urandom);
        i_joy2      <= joy_t'($urandom);
        repeat (8) @(posedge clk);
        resetn <= 1'b1;
        // SDRAM init keeps the boot loader waiting for a while
        repeat (12) @(posedge clk);
        i_ram_busy <= 1'b0;
        @(negedge clk);
        // Last boot write may still be inside the memory
        while (!o_cpu_resetn || mem_busy) begin
            @(negedge clk);
        end

        // Word 0 holds the first four firmware bytes
        wv = {flash_bytes[3], flash_bytes[2], flash_bytes[1], flash_bytes[0]};
        expect_read(32'h0, '1, wv, wv);
        for (int i = 0; i < 4; i++) begin
            ra = {22'd0, 8'(64 + $urandom % 192), 2'b00};
            wv = $urandom;
            write_word(ra, wv);
            expect_read(ra, '1, wv, wv);
        end

        // Second data write restarts the byte sequence
        write_word(REG_ROM_DATA, $urandom);
        repeat (6) @(posedge clk);
        write_word(REG_ROM_DATA, $urandom);
        repeat (20) @(posedge clk);
        write_word(REG_ROM_CTRL, 32'd1);
        repeat (3) @(posedge clk);
        write_word(REG_ROM_CTRL, 32'd0);
        repeat (3) @(posedge clk);

        write_word(REG_SYS_TYPE, 32'd2);
        expect_read(REG_SYS_TYPE, 32'h3, 32'd2, 32'd2);
        write_word(REG_ASPECT, 32'd1);
        expect_read(REG_ASPECT, 32'h1, 32'd1, 32'd1);
        write_word(REG_ENH_APU, 32'd1);
        expect_read(REG_ENH_APU, 32'h1, 32'd1, 32'd1);
        write_word(REG_OVERLAY, 32'h0200_0000);
        expect_read(REG_OVERLAY, 32'h0300_0000, 32'h0200_0000, 32'h0200_0000);
        write_word(REG_OVERLAY, 32'h0100_0000);
        expect_read(REG_OVERLAY, 32'h0300_0000, 32'h0100_0000, 32'h0100_0000);

        expect_read(REG_CORE_ID, 32'h0000_ffff, 32'd2, 32'd2);
        // Joystick 2 sits at bit 16 and joystick 1 at bit 0
        wv = (word_t'(i_joy2) << 16) | word_t'(i_joy1);
        expect_read(REG_JOY, 32'h0fff_0fff, wv, wv);
        // Each access spans two edges, so samples are the wait plus two apart
        read_word(REG_TIME_MS, t_first);
        repeat (TIME_GAP - 2) @(posedge clk);
        expect_read(REG_TIME_MS, '1, t_first + TIME_GAP / CYC_PER_MS,
                    t_first + (TIME_GAP + CYC_PER_MS - 1) / CYC_PER_MS);
        read_word(REG_CYCLES, t_first);
        repeat (CYC_GAP - 2) @(posedge clk);
        expect_read(REG_CYCLES, '1, t_first + CYC_GAP, t_first + CYC_GAP);

        repeat (5) @(posedge clk);
        $display("Summary: %0d errors in %0d bus accesses", errors, accesses);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
